//--- run_sim.sh
#!/bin/sh
# build and run the panel decoder testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_panel_ctrl \
    -Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_panel_ctrl > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
exit 0

//--- verif/panel_ctrl_chk.sv
/*
 * panel_ctrl_chk: protocol assertions on the command dispatcher
 */
module panel_ctrl_chk import panel_pkg::*; (
    input logic       clk_in,
    input logic       reset,
    input cmd_state_t state,
    input logic       ram_write_enable,
    input logic       ready_for_data,
    input logic       pix_start,
    input logic       pix_arg_valid,
    input logic       blank_start,
    input logic       blank_write,
    input logic       blank_arg_valid
);
    logic [2:0] pix_args;

    // argument pulses since the last pixel start
    always_ff @(posedge clk_in) begin
        if (reset || pix_start) begin
            pix_args <= '0;
        end else if (pix_arg_valid) begin
            pix_args <= pix_args + 3'd1;
        end
    end

    // the write port trails the writer request by two cycles
    assert property (@(posedge clk_in)
        ram_write_enable |-> $past(state, 2) != IDLE)
        else $error("RAM write issued in reset or while the FSM was idle");

    assert property (@(posedge clk_in) disable iff (reset)
        (blank_start || blank_write) |-> !ready_for_data)
        else $error("ready_for_data high during the blank sweep");

    // only four arguments belong to one P command
    assert property (@(posedge clk_in) disable iff (reset)
        pix_arg_valid |-> pix_args < 3'd4)
        else $error("argument byte sent to the idle pixel writer");

    // the blanker takes no arguments
    assert property (@(posedge clk_in) disable iff (reset)
        !blank_arg_valid)
        else $error("argument byte sent to the idle blanker");
endmodule

bind cmd_dispatch panel_ctrl_chk chk0 (
    .clk_in           (clk_in),
    .reset            (reset),
    .state            (state),
    .ram_write_enable (ram_write_enable),
    .ready_for_data   (ready_for_data),
    .pix_start        (pix_cmd.start),
    .pix_arg_valid    (pix_cmd.arg_valid),
    .blank_start      (blank_cmd.start),
    .blank_write      (blank_ram.write),
    .blank_arg_valid  (blank_cmd.arg_valid)
);

//--- verif/tb_clock_gen.sv
/*
 * tb_clock_gen: free-running testbench clock and power-on reset
 */
module tb_clock_gen (
    output logic clk_in,
    output logic reset
);
    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk_in = 1'b0;
        forever #HALF_PERIOD clk_in = ~clk_in;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_in);
        #1;
        reset = 1'b0;
    end
endmodule

//--- verif/tb_panel_ctrl.sv
/*
 * tb_panel_ctrl: sends command bytes to the panel decoder and checks
 * settings outputs and frame RAM writes against a reference model
 */
module tb_panel_ctrl;
    localparam logic [31:0] SEED = 32'h33ff24b5;
    // byte budget plus two blank sweeps and the check gaps
    localparam int MAX_BYTES  = 128;
    localparam int RUN_CYCLES = MAX_BYTES + 2 * 4096 + 12 * 8 + 500;

    logic        clk_in, reset, data_ready_n, ram_write_enable, busy, ready_for_data;
    logic [7:0]  data_rx, ram_data_out;
    logic [2:0]  rgb_enable, exp_rgb;
    logic [5:0]  brightness_enable, exp_bright;
    logic [11:0] ram_address;
    logic [7:0]  ram_model [4096];
    logic [7:0]  exp_mem [4096];
    logic [31:0] lfsr_state;
    int          write_count, exp_writes, mismatch_count, other_errors, low_cycles;
    bit          compare_req;
    string       cur_test;

    tb_clock_gen clk_gen0 (.clk_in(clk_in), .reset(reset));

    panel_ctrl_top dut0 (
        .clk_in            (clk_in),
        .reset             (reset),
        .data_rx           (data_rx),
        .data_ready_n      (data_ready_n),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .ram_data_out      (ram_data_out),
        .ram_address       (ram_address),
        .ram_write_enable  (ram_write_enable),
        .busy              (busy),
        .ready_for_data    (ready_for_data)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // expected {rgb, brightness} after one command byte or one T argument
    function automatic logic [8:0] settings_ref(input logic [8:0] cur, input logic [7:0] b,
                                                input logic is_t_arg);
        logic [2:0] rgb;
        logic [5:0] br;
        logic [2:0] bit_idx;
        rgb     = cur[8:6];
        br      = cur[5:0];
        bit_idx = 3'd6 - b[2:0];
        if (is_t_arg) begin
            br = b[5:0];
        end else begin
            case (b)
                "R": rgb[0] = 1'b1;
                "r": rgb[0] = 1'b0;
                "G": rgb[1] = 1'b1;
                "g": rgb[1] = 1'b0;
                "B": rgb[2] = 1'b1;
                "b": rgb[2] = 1'b0;
                "0": br = '0;
                "9": br = '1;
                "1", "2", "3", "4", "5", "6": br[bit_idx] = ~br[bit_idx];
                default: ;
            endcase
        end
        return {rgb, br};
    endfunction

    // high colour byte sits at byte_sel 1, the lsb
    function automatic logic [11:0] pixel_addr(input logic [7:0] row, input logic [7:0] col,
                                               input logic sel);
        return {row[4:0], col[5:0], sel};
    endfunction

    function automatic logic [7:0] fill_byte(input logic [11:0] a);
        return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h5a;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            mismatch_count++;
            $display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // frame memory as seen on the write port
    initial begin
        write_count = 0;
        for (int a = 0; a < 4096; a++) begin
            ram_model[12'(a)] = fill_byte(12'(a));
        end
        forever begin
            @(negedge clk_in);
            if (ram_write_enable === 1'b1) begin
                ram_model[ram_address] = ram_data_out;
                write_count++;
            end
        end
    end

    initial begin
        forever begin
            wait (compare_req);
            check_value({cur_test, " rgb"}, 32'(exp_rgb), 32'(rgb_enable));
            check_value({cur_test, " brightness"}, 32'(exp_bright), 32'(brightness_enable));
            check_value({cur_test, " busy"}, 32'd0, 32'(busy));
            check_value({cur_test, " ready"}, 32'd1, 32'(ready_for_data));
            check_value({cur_test, " writes"}, 32'(exp_writes), 32'(write_count));
            for (int a = 0; a < 4096; a++) begin
                check_value($sformatf("%s mem[%03h]", cur_test, a),
                            32'(exp_mem[12'(a)]), 32'(ram_model[12'(a)]));
            end
            compare_req = 1'b0;
        end
    end

    task automatic send_byte(input logic [7:0] b);
        while (!ready_for_data) begin
            @(posedge clk_in);
            #1;
        end
        data_rx      = b;
        data_ready_n = 1'b0;
        @(posedge clk_in);
        #1;
        data_ready_n = 1'b1;
    endtask

    task automatic send_setting(input logic [7:0] b);
        send_byte(b);
        {exp_rgb, exp_bright} = settings_ref({exp_rgb, exp_bright}, b, 1'b0);
    endtask

    task automatic load_brightness(input logic [7:0] arg);
        send_byte("T");
        send_byte(arg);
        {exp_rgb, exp_bright} = settings_ref({exp_rgb, exp_bright}, arg, 1'b1);
    endtask

    task automatic write_pixel(input logic [7:0] row, input logic [7:0] col,
                               input logic [7:0] hi, input logic [7:0] lo);
        send_byte("P");
        send_byte(row);
        // busy from the cycle after P is seen
        check_value("pixel busy", 32'd1, 32'(busy));
        send_byte(col);
        send_byte(hi);
        send_byte(lo);
        exp_mem[pixel_addr(row, col, 1'b1)] = hi;
        exp_mem[pixel_addr(row, col, 1'b0)] = lo;
        exp_writes += 2;
    endtask

    task automatic write_random_pixel();
        write_pixel(8'(next_bits(8)), 8'(next_bits(8)), 8'(next_bits(8)), 8'(next_bits(8)));
    endtask

    task automatic blank_panel();
        send_byte("Z");
        low_cycles = 0;
        while (!ready_for_data) begin
            low_cycles++;
            @(posedge clk_in);
            #1;
        end
        if (low_cycles < 4096) begin
            other_errors++;
            $display("ready_for_data returned after %0d cycles, before the sweep ended",
                     low_cycles);
        end
        for (int a = 0; a < 4096; a++) begin
            exp_mem[12'(a)] = 8'h00;
        end
        exp_writes += 4096;
    endtask

    task automatic run_check(input string name);
        repeat (6) @(posedge clk_in);
        #1;
        cur_test    = name;
        compare_req = 1'b1;
        wait (!compare_req);
    endtask

    initial begin
        logic [2:0] pick;
        logic [7:0] rgb_cmds [6];
        rgb_cmds       = '{"R", "r", "G", "g", "B", "b"};
        data_rx        = 8'h00;
        data_ready_n   = 1'b1;
        lfsr_state     = SEED;
        exp_rgb        = '1;
        exp_bright     = '1;
        exp_writes     = 0;
        mismatch_count = 0;
        other_errors   = 0;
        for (int a = 0; a < 4096; a++) begin
            exp_mem[12'(a)] = fill_byte(12'(a));
        end
        wait (reset === 1'b0);
        @(posedge clk_in);
        #1;
        run_check("reset");

        for (int i = 0; i < 24; i++) begin
            pick = 3'(next_bits(3));
            if (pick > 3'd5) begin
                pick = pick - 3'd6;
            end
            send_setting(rgb_cmds[pick]);
        end
        run_check("rgb sequence");

        send_setting("0");
        send_setting("1");
        send_setting("4");
        run_check("brightness digits");
        send_setting("9");
        send_setting("6");
        send_setting("2");
        send_setting("x");
        send_setting("3");
        send_setting("5");
        run_check("brightness toggles");
        for (int i = 0; i < 3; i++) begin
            load_brightness(8'(next_bits(8)));
            send_setting("1");
        end
        run_check("brightness load");

        for (int i = 0; i < 6; i++) begin
            write_random_pixel();
        end
        run_check("pixel writes");

        write_random_pixel();
        write_random_pixel();
        blank_panel();
        run_check("panel blank");

        // second sweep with a new pixel straight after it
        blank_panel();
        write_random_pixel();
        send_setting("r");
        send_setting("3");
        write_random_pixel();
        send_setting("B");
        run_check("pixel after blank");

        $display("Errors: %0d value mismatches, %0d other failures",
                 mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(RUN_CYCLES * 10);
        $display("Watchdog expired: tests did not finish within %0d cycles", RUN_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end
endmodule

//--- verilog.f
verilog/panel_pkg.sv
verilog/panel_if.sv
verilog/cmd_dispatch.sv
verilog/display_settings.sv
verilog/pixel_writer.sv
verilog/panel_blanker.sv
verilog/panel_ctrl_top.sv
verif/tb_clock_gen.sv
verif/panel_ctrl_chk.sv
verif/tb_panel_ctrl.sv

//--- verilog/cmd_dispatch.sv
/*
 * cmd_dispatch: registers incoming bytes, runs the command FSM and
 * hands arguments to the engines; owns the registered RAM write port
 */
module cmd_dispatch import panel_pkg::*; (
    input  logic                 clk_in,
    input  logic                 reset,
    input  logic [7:0]           data_rx,
    input  logic                 data_ready_n,
    output logic                 ready_for_data,
    output logic                 busy,
    output logic [ADDR_BITS-1:0] ram_address,
    output logic [7:0]           ram_data_out,
    output logic                 ram_write_enable,
    output logic                 settings_cmd,
    output logic                 brightness_arg,
    output logic [7:0]           settings_byte,
    cmd_engine_if.dispatch       pix_cmd,
    cmd_engine_if.dispatch       blank_cmd,
    ram_req_if.port              pix_ram,
    ram_req_if.port              blank_ram
);
    cmd_state_t state;
    cmd_state_t state_next;
    logic [7:0] byte_reg;
    logic       seen;
    logic       decode_now;
    ram_addr_t  req_addr;
    logic [7:0] req_data;
    logic       req_write;

    // byte capture
    always_ff @(posedge clk_in) begin
        if (reset) begin
            seen <= 1'b0;
        end else begin
            seen <= ~data_ready_n & ready_for_data;
        end
    end

    always_ff @(posedge clk_in) begin
        if (~data_ready_n & ready_for_data) begin
            byte_reg <= data_rx;
        end
    end

    // a byte arriving with the pixel done pulse is already a new command
    assign decode_now = seen &&
        (state == IDLE || (state == WRITE_PIXEL && pix_cmd.done));

    always_comb begin
        state_next      = state;
        settings_cmd    = 1'b0;
        pix_cmd.start   = 1'b0;
        blank_cmd.start = 1'b0;
        if (decode_now) begin
            case (byte_reg)
                CMD_LOAD_BRIGHTNESS: state_next = LOAD_BRIGHTNESS;
                CMD_WRITE_PIXEL: begin
                    state_next    = WRITE_PIXEL;
                    pix_cmd.start = 1'b1;
                end
                CMD_BLANK: begin
                    state_next      = BLANK;
                    blank_cmd.start = 1'b1;
                end
                default: begin
                    state_next   = IDLE;
                    settings_cmd = 1'b1;
                end
            endcase
        end else begin
            case (state)
                LOAD_BRIGHTNESS: if (seen) state_next = IDLE;
                WRITE_PIXEL:     if (pix_cmd.done) state_next = IDLE;
                BLANK:           if (blank_cmd.done) state_next = IDLE;
                default:         state_next = state;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign settings_byte  = byte_reg;
    assign brightness_arg = seen && state == LOAD_BRIGHTNESS;

    assign pix_cmd.arg_valid   = seen && state == WRITE_PIXEL && !pix_cmd.done;
    assign pix_cmd.arg_byte    = byte_reg;
    assign blank_cmd.arg_valid = seen && state == BLANK;
    assign blank_cmd.arg_byte  = byte_reg;

    assign busy = state != IDLE;

    // Z holds off the next byte as soon as it is seen
    assign ready_for_data = state != BLANK && !(decode_now && byte_reg == CMD_BLANK);

    // only one writer is ever active, pick whichever requests
    always_ff @(posedge clk_in) begin
        if (reset) begin
            req_write <= 1'b0;
        end else begin
            req_write <= pix_ram.write | blank_ram.write;
        end
    end

    always_ff @(posedge clk_in) begin
        if (blank_ram.write) begin
            req_addr <= blank_ram.addr;
            req_data <= blank_ram.data;
        end else begin
            req_addr <= pix_ram.addr;
            req_data <= pix_ram.data;
        end
    end

    // output stage
    always_ff @(posedge clk_in) begin
        if (reset) begin
            ram_write_enable <= 1'b0;
        end else begin
            ram_write_enable <= req_write;
        end
    end

    always_ff @(posedge clk_in) begin
        ram_address  <= req_addr.flat;
        ram_data_out <= req_data;
    end

endmodule

//--- verilog/display_settings.sv
/*
 * display_settings: colour enables and brightness mask, driven by the
 * single-byte commands and the T argument
 */
module display_settings import panel_pkg::*; (
    input  logic                         clk_in,
    input  logic                         reset,
    input  logic                         settings_cmd,
    input  logic                         brightness_arg,
    input  logic [7:0]                   settings_byte,
    output logic [RGB_CHANNELS-1:0]      rgb_enable,
    output logic [BRIGHTNESS_LEVELS-1:0] brightness_enable
);
    logic [RGB_CHANNELS-1:0]      rgb_next;
    logic [BRIGHTNESS_LEVELS-1:0] mask;
    logic [BRIGHTNESS_LEVELS-1:0] mask_next;

    always_comb begin
        rgb_next  = rgb_enable;
        mask_next = mask;
        if (brightness_arg) begin
            mask_next = settings_byte[BRIGHTNESS_LEVELS-1:0];
        end else if (settings_cmd) begin
            case (settings_byte)
                CMD_RED_ON:       rgb_next[0] = 1'b1;
                CMD_RED_OFF:      rgb_next[0] = 1'b0;
                CMD_GREEN_ON:     rgb_next[1] = 1'b1;
                CMD_GREEN_OFF:    rgb_next[1] = 1'b0;
                CMD_BLUE_ON:      rgb_next[2] = 1'b1;
                CMD_BLUE_OFF:     rgb_next[2] = 1'b0;
                CMD_BRIGHT_CLEAR: mask_next = '0;
                CMD_BRIGHT_SET:   mask_next = '1;
                default: begin
                    // digit n toggles bit n counted from the msb
                    for (int i = 1; i <= BRIGHTNESS_LEVELS; i++) begin
                        if (settings_byte == CMD_BRIGHT_CLEAR + 8'(i)) begin
                            mask_next[BRIGHTNESS_LEVELS-i] = ~mask[BRIGHTNESS_LEVELS-i];
                        end
                    end
                end
            endcase
        end
    end

    // brightness_enable trails the staged mask by one cycle
    always_ff @(posedge clk_in) begin
        if (reset) begin
            rgb_enable        <= '1;
            mask              <= '1;
            brightness_enable <= '1;
        end else begin
            rgb_enable        <= rgb_next;
            mask              <= mask_next;
            brightness_enable <= mask;
        end
    end

endmodule

//--- verilog/panel_blanker.sv
/*
 * panel_blanker: writes zero to every frame RAM byte, one per cycle
 */
module panel_blanker import panel_pkg::*; (
    input  logic         clk_in,
    input  logic         reset,
    cmd_engine_if.engine cmd,
    ram_req_if.writer    ram
);
    logic                 active;
    logic [ADDR_BITS-1:0] sweep_addr;
    logic                 last_addr;

    assign last_addr = &sweep_addr;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            active     <= 1'b0;
            sweep_addr <= '0;
        end else if (cmd.start) begin
            active     <= 1'b1;
            sweep_addr <= '0;
        end else if (active) begin
            sweep_addr <= sweep_addr + 1'b1;
            if (last_addr) begin
                active <= 1'b0;
            end
        end
    end

    // one request per active cycle
    assign ram.write     = active;
    assign ram.addr.flat = sweep_addr;
    assign ram.data      = 8'h00;
    assign cmd.done      = active && last_addr;

endmodule

//--- verilog/panel_ctrl_top.sv
/*
 * panel_ctrl_top: byte command decoder for the LED matrix driver,
 * dispatcher plus settings block and the two frame RAM writers
 */
module panel_ctrl_top import panel_pkg::*; (
    input  logic                         clk_in,
    input  logic                         reset,
    input  logic [7:0]                   data_rx,
    input  logic                         data_ready_n,
    output logic [RGB_CHANNELS-1:0]      rgb_enable,
    output logic [BRIGHTNESS_LEVELS-1:0] brightness_enable,
    output logic [7:0]                   ram_data_out,
    output logic [ADDR_BITS-1:0]         ram_address,
    output logic                         ram_write_enable,
    output logic                         busy,
    output logic                         ready_for_data
);
    logic       settings_cmd;
    logic       brightness_arg;
    logic [7:0] settings_byte;

    cmd_engine_if pix_cmd ();
    cmd_engine_if blank_cmd ();
    ram_req_if    pix_ram ();
    ram_req_if    blank_ram ();

    cmd_dispatch dispatch0 (
        .clk_in           (clk_in),
        .reset            (reset),
        .data_rx          (data_rx),
        .data_ready_n     (data_ready_n),
        .ready_for_data   (ready_for_data),
        .busy             (busy),
        .ram_address      (ram_address),
        .ram_data_out     (ram_data_out),
        .ram_write_enable (ram_write_enable),
        .settings_cmd     (settings_cmd),
        .brightness_arg   (brightness_arg),
        .settings_byte    (settings_byte),
        .pix_cmd          (pix_cmd.dispatch),
        .blank_cmd        (blank_cmd.dispatch),
        .pix_ram          (pix_ram.port),
        .blank_ram        (blank_ram.port)
    );

    display_settings settings0 (
        .clk_in            (clk_in),
        .reset             (reset),
        .settings_cmd      (settings_cmd),
        .brightness_arg    (brightness_arg),
        .settings_byte     (settings_byte),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable)
    );

    pixel_writer pixel0 (
        .clk_in (clk_in),
        .reset  (reset),
        .cmd    (pix_cmd.engine),
        .ram    (pix_ram.writer)
    );

    panel_blanker blank0 (
        .clk_in (clk_in),
        .reset  (reset),
        .cmd    (blank_cmd.engine),
        .ram    (blank_ram.writer)
    );

endmodule

//--- verilog/panel_if.sv
/*
 * links between the command dispatcher and the RAM writing engines:
 * command start, argument bytes and done, plus the write request
 */
interface cmd_engine_if ();
    logic       start;
    logic       arg_valid;
    logic [7:0] arg_byte;
    logic       done;

    modport dispatch (
        output start,
        output arg_valid,
        output arg_byte,
        input  done
    );

    modport engine (
        input  start,
        input  arg_valid,
        input  arg_byte,
        output done
    );
endinterface

interface ram_req_if import panel_pkg::*; ();
    ram_addr_t  addr;
    logic [7:0] data;
    logic       write;

    modport writer (
        output addr,
        output data,
        output write
    );

    modport port (
        input addr,
        input data,
        input write
    );
endinterface

//--- verilog/panel_pkg.sv
/*
 * panel_pkg: shared geometry, command codes and types for the
 * 64x32 RGB matrix command decoder
 */
package panel_pkg;

    // frame RAM geometry, two bytes per pixel
    localparam int ROW_BITS      = 5;
    localparam int COL_BITS      = 6;
    localparam int BYTE_SEL_BITS = 1;
    localparam int ADDR_BITS     = ROW_BITS + COL_BITS + BYTE_SEL_BITS;

    localparam int BRIGHTNESS_LEVELS = 6;
    localparam int RGB_CHANNELS      = 3;

    // colour channel enables
    localparam logic [7:0] CMD_RED_ON    = "R";
    localparam logic [7:0] CMD_RED_OFF   = "r";
    localparam logic [7:0] CMD_GREEN_ON  = "G";
    localparam logic [7:0] CMD_GREEN_OFF = "g";
    localparam logic [7:0] CMD_BLUE_ON   = "B";
    localparam logic [7:0] CMD_BLUE_OFF  = "b";

    // brightness digits, 1..6 count up from this one
    localparam logic [7:0] CMD_BRIGHT_CLEAR = "0";
    localparam logic [7:0] CMD_BRIGHT_SET   = "9";

    // multi-byte commands
    localparam logic [7:0] CMD_LOAD_BRIGHTNESS = "T";
    localparam logic [7:0] CMD_WRITE_PIXEL     = "P";
    localparam logic [7:0] CMD_BLANK           = "Z";

    typedef struct packed {
        logic [ROW_BITS-1:0]      row;
        logic [COL_BITS-1:0]      column;
        logic [BYTE_SEL_BITS-1:0] byte_sel;
    } ram_fields_t;

    // same word seen flat on the port or split into pixel fields
    typedef union packed {
        logic [ADDR_BITS-1:0] flat;
        ram_fields_t          fields;
    } ram_addr_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD_BRIGHTNESS,
        WRITE_PIXEL,
        BLANK
    } cmd_state_t;

endpackage

//--- verilog/pixel_writer.sv
/*
 * pixel_writer: gathers the four P arguments and writes the two
 * colour bytes of one pixel, little-endian
 */
module pixel_writer import panel_pkg::*; (
    input  logic         clk_in,
    input  logic         reset,
    cmd_engine_if.engine cmd,
    ram_req_if.writer    ram
);
    logic [1:0]          arg_count;
    logic [ROW_BITS-1:0] row;
    logic [COL_BITS-1:0] column;

    // args: row, column, high colour, low colour
    always_ff @(posedge clk_in) begin
        if (reset) begin
            arg_count <= 2'd0;
            ram.write <= 1'b0;
            cmd.done  <= 1'b0;
        end else begin
            ram.write <= 1'b0;
            cmd.done  <= 1'b0;
            if (cmd.start) begin
                arg_count <= 2'd0;
            end else if (cmd.arg_valid) begin
                arg_count <= arg_count + 2'd1;
                ram.write <= arg_count[1];
                cmd.done  <= arg_count == 2'd3;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (cmd.arg_valid) begin
            case (arg_count)
                2'd0: row    <= cmd.arg_byte[ROW_BITS-1:0];
                2'd1: column <= cmd.arg_byte[COL_BITS-1:0];
                default: begin
                    ram.addr.fields.row    <= row;
                    ram.addr.fields.column <= column;
                    // high byte lands at byte_sel 1
                    ram.addr.fields.byte_sel <= BYTE_SEL_BITS'(~arg_count[0]);
                    ram.data <= cmd.arg_byte;
                end
            endcase
        end
    end

endmodule
